// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --timescale 1ns/1ns
TOP = uopSequencerTb
FILELIST = src.f
LOG = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: common/uopPkg.sv
// Micro-op sequencer definitions
package uopPkg;

	parameter int InstrWidth = 32;   // Instruction word size
	parameter int RegListWidth = 16; // LDM register list size

	localparam logic [3:0] RegRz = 4'd15; // Scratch, upper half of extended file
	localparam logic [3:0] RegLr = 4'd14;
	localparam logic [3:0] RegPc = 4'd15;

	localparam logic [3:0] OpMov = 4'b1101;
	localparam logic [3:0] OpAdd = 4'b0100;
	localparam logic [3:0] CondNever = 4'b1111; // NV, never executes

	localparam int WordBytes = 4; // LDR step between listed registers

	// Op class field, bits 27:25
	localparam logic [2:0] ClassDpReg = 3'b000; // Data processing, register operand
	localparam logic [2:0] ClassDpImm = 3'b001; // Data processing, immediate
	localparam logic [2:0] ClassSingle = 3'b010; // LDR/STR with immediate offset
	localparam logic [2:0] ClassBlock = 3'b100; // LDM/STM

	// Rz select: {RA1 mux, WA3 high, RA2 high, RA1 high}
	localparam logic [3:0] RzWrite = 4'b1100; // First half writes Rz
	localparam logic [3:0] RzReadRa2 = 4'b0010; // Rz as shifted operand
	localparam logic [3:0] RzReadRa1 = 4'b0001; // Rz as first operand

	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] opClass;
		logic [3:0] opcode; // Bit 24 doubles as the BL link bit
		logic s;            // Also L for transfers
		logic [3:0] rn;     // Rd for multiplies
		logic [3:0] rd;     // Rn or accumulator for multiplies
		logic [InstrWidth-21:0] operand2;
	} dpView_t;

	typedef struct packed {
		logic [3:0] rd;
		logic [11:0] offset;
	} singleXfer_t;

	// Low half is a register list for LDM and Rd plus offset for LDR
	typedef union packed {
		logic [RegListWidth-1:0] regList;
		singleXfer_t single;
	} xferLow_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [2:0] opClass;
		logic p; // Pre-index, before for blocks
		logic u; // Add offset, increment for blocks
		logic b;
		logic w;
		logic l; // Load
		logic [3:0] rn;
		xferLow_t low;
	} blkView_t;

	typedef union packed {
		dpView_t dp;
		blkView_t blk;
	} instrWord_t;

	typedef struct packed {
		logic instrMux;     // Micro-op replaces fetched word
		logic noFlagUpdate;
		logic uopStall;     // Hold fetch and decode
		logic keepV;        // Preserve overflow flag
		logic prevRsr;      // Previous micro-op was a first half
		logic ldmForward;   // Base is previous access address
		logic [3:0] regFileRz;
	} uopCtrl_t;

	typedef enum logic [2:0] {stReady, stRsr, stMla, stBl, stLdm} uopState_t;

	typedef enum logic [2:0] {clPass, clRsr, clMla, clBl, clLdm} instrClass_t;

endpackage

// File: dv/clockGen.sv
// Testbench clock and reset
`timescale 1ns/1ns
module clockGen #(
	parameter int Period = 10,     // ns
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clk); // Sync reset seen on each edge
		#1;
		reset = 1'b0;
	end

endmodule

// File: dv/uopTests.svh
// Directed sequencer tests
`ifndef UOP_TESTS_SVH
`define UOP_TESTS_SVH

// Flag bits are {instrMux, noFlagUpdate, uopStall, keepV, prevRsr, ldmForward}
function automatic uopCtrl_t makeCtrl(input logic [5:0] bits, input logic [3:0] rz);
	uopCtrl_t c;
	c.instrMux = bits[5];
	c.noFlagUpdate = bits[4];
	c.uopStall = bits[3];
	c.keepV = bits[2];
	c.prevRsr = bits[1];
	c.ldmForward = bits[0];
	c.regFileRz = rz;
	return c;
endfunction

task automatic beginTest(input string name);
	testName = name;
	testErrors = 0;
endtask

task automatic endTest();
	testsRun++;
	if (testErrors == 0) begin
		$display("%s: ok", testName);
	end else begin
		testsFailed++;
		$display("%s: %0d mismatches", testName, testErrors);
	end
endtask

// Sample mid-cycle, then move to the next drive point
task automatic expectCycle(input string label, input logic [31:0] word, input uopCtrl_t c);
	@(negedge clk);
	checkValue({label, " word"}, word, uopInstr);
	checkValue({label, " ctrl"}, 32'(c), 32'(ctrl));
	@(posedge clk);
	#1;
endtask

task automatic testPassThrough();
	logic [31:0] word;
	beginTest("passThrough");
	word = {4'b1110, 3'b001, OpAdd, 1'b1, 4'd2, 4'd3, 12'(nextRandom())}; // ADD immediate
	instr = word;
	expectCycle("add", word, '0);
	endTest();
endtask

task automatic testRsr();
	logic [31:0] word;
	logic [31:0] first;
	uopCtrl_t firstCtrl;
	beginTest("rsr");
	word = nextRandom();
	word[27:25] = 3'b000;
	word[7] = 1'b0; // Shift amount from Rs
	word[4] = 1'b1;
	first = {word[31:25], OpMov, 1'b0, 4'd0, RegRz, word[11:0]};
	firstCtrl = makeCtrl(6'b111000, RzWrite);
	instr = word;
	stall = 1'b1;
	expectCycle("first", first, firstCtrl);
	expectCycle("held", first, firstCtrl);
	stall = 1'b0;
	expectCycle("released", first, firstCtrl);
	expectCycle("second", {word[31:12], 8'd0, RegRz}, makeCtrl(6'b100010, RzReadRa2));
	endTest();
endtask

task automatic testMla();
	logic [31:0] word;
	beginTest("mla");
	word = nextRandom();
	word[27:23] = 5'b00000; // Short multiply, sign bit left random
	word[21] = 1'b1;        // Accumulate
	word[7:4] = 4'b1001;
	instr = word;
	expectCycle("mul", {word[31:25], 2'b00, word[22], 1'b0, 1'b0, RegRz, 4'd0, word[11:0]},
		makeCtrl(6'b111000, RzWrite));
	expectCycle("add", {word[31:25], OpAdd, word[20], RegRz, word[19:16], 8'd0, word[15:12]},
		makeCtrl(6'b100110, RzReadRa1));
	word[23] = 1'b1; // Long form is not expanded
	instr = word;
	expectCycle("long", word, '0);
	endTest();
endtask

task automatic testBl();
	logic [31:0] word;
	logic [31:0] branch;
	beginTest("bl");
	word = nextRandom();
	word[27:24] = 4'b1011;
	branch = word;
	branch[24] = 1'b0; // Link bit dropped
	instr = word;
	expectCycle("mov", {word[31:28], 3'b000, OpMov, 1'b0, 4'd0, RegLr, 8'd0, RegPc},
		makeCtrl(6'b101000, 4'd0));
	expectCycle("branch", branch, makeCtrl(6'b100000, 4'd0));
	endTest();
endtask

// Mode is {P, U} and the flags satisfy cond
task automatic runLdm(input logic [1:0] mode, input logic [3:0] cond, input logic [3:0] nzcv);
	logic [31:0] word;
	logic [15:0] list;
	logic [11:0] offset;
	logic up;
	bit first;
	int n;
	list = 16'(nextRandom());
	if (list == '0) begin
		list = 16'h0001;
	end
	n = 0;
	for (int i = 0; i < 16; i++) begin
		n += int'(list[i]);
	end
	case (mode)
		2'b00: offset = 12'((n - 1) * 4); // DA
		2'b01: offset = 12'd0;            // IA
		2'b10: offset = 12'(n * 4);       // DB
		default: offset = 12'd4;          // IB
	endcase
	word = {cond, 3'b100, mode, 3'b001, 4'(nextRandom()), list};
	instr = word;
	flags = nzcv;
	first = 1'b1;
	up = mode[0];
	for (int i = 0; i < 16; i++) begin
		if (list[i]) begin
			n--;
			expectCycle($sformatf("ldr r%0d", i),
				{cond, 3'b010, 1'b1, up, 3'b001, word[19:16], 4'(i), offset},
				makeCtrl({2'b11, n != 0, 2'b00, !first}, 4'd0));
			first = 1'b0;
			offset = 12'd4; // Later loads step up from the previous address
			up = 1'b1;
		end
	end
endtask

task automatic testLdm();
	beginTest("ldm");
	runLdm(2'b00, 4'b0000, 4'b0100); // EQ with Z set
	runLdm(2'b01, 4'b0001, 4'b0000); // NE
	runLdm(2'b10, 4'b1010, 4'b1001); // GE with N equal to V
	runLdm(2'b11, 4'b1110, 4'b0000); // AL
	endTest();
endtask

task automatic testLdmFlush();
	logic [15:0] list;
	logic [31:0] next;
	beginTest("ldmFlush");
	list = 16'(nextRandom()) | 16'h0101; // At least two loads with r0 first
	instr = {4'b0000, 3'b100, 2'b01, 3'b001, 4'd5, list}; // LDMEQ IA
	flags = 4'b0100;
	expectCycle("ldr r0", {4'b0000, 3'b010, 2'b11, 3'b001, 4'd5, 4'd0, 12'd0},
		makeCtrl(6'b111000, 4'd0));
	flags = 4'b0000; // EQ now fails
	expectCycle("flush", {CondNever, 3'b001, OpAdd, 1'b0, 4'd0, 4'd0, 12'd0},
		makeCtrl(6'b010000, 4'd0));
	next = {4'b1110, 3'b001, OpAdd, 1'b0, 4'd1, 4'd1, 12'(nextRandom())};
	instr = next;
	expectCycle("after", next, '0);
	endTest();
endtask

`endif

// File: dv/uopSequencerTb.sv
// Micro-op sequencer testbench
`timescale 1ns/1ns
module uopSequencerTb;
	import uopPkg::*;

	localparam int ClockPeriod = 10;
	localparam int TestCycles = 80; // Reset, fixed tests and four LDMs of up to 16 loads
	localparam int WatchdogNs = TestCycles * ClockPeriod * 4;

	logic clk;
	logic reset;
	instrWord_t instr;
	logic [3:0] flags; // NZCV
	logic stall;
	instrWord_t uopInstr;
	uopCtrl_t ctrl;

	string testName;
	int testErrors;   // Mismatches in the running test
	int errorCount;
	int checkCount;
	int testsRun;
	int testsFailed;
	logic [31:0] lcgState;

	clockGen #(.Period(ClockPeriod), .ResetCycles(3)) i_clockGen (.clk(clk), .reset(reset));

	uopSequencer #(
		.RegCount(16)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.flags(flags),
		.stall(stall),
		.uopInstr(uopInstr),
		.ctrl(ctrl)
	);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkValue(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			$display("[ERROR] %s %s: expected %h, actual %h", testName, label, expected, actual);
			testErrors++;
			errorCount++;
		end
	endtask

	`include "uopTests.svh"

	initial begin
		#(WatchdogNs);
		$display("Timeout: the tests were still running after %0d ns", WatchdogNs);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		instr = '0;
		flags = 4'b0000;
		stall = 1'b0;
		lcgState = 32'h8b61_6347;
		errorCount = 0;
		checkCount = 0;
		testsRun = 0;
		testsFailed = 0;
		@(negedge reset); // Released just after a rising edge
		testPassThrough();
		testRsr();
		testMla();
		testBl();
		testLdm();
		testLdmFlush();
		$display("Tests %0d, failed %0d, checks %0d, mismatches %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: ldm/ldmPlanner.sv
// Load multiple planner
`timescale 1ns/1ns
module ldmPlanner #(
	parameter int RegCount = 16
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic inReady,
	input uopPkg::instrWord_t instr,
	output logic [3:0] nextReg,
	output logic [11:0] firstOffset,
	output logic addUp,
	output logic lastXfer
);
	import uopPkg::*;

	logic [RegCount-1:0] fullList; // List of the held LDM
	logic [RegCount-1:0] remList;  // Registers still to load
	logic [RegCount-1:0] curList;
	logic [RegCount-1:0] restList;
	logic [11:0] listCount;
	logic [11:0] stepBytes;

	assign fullList = instr.blk.low.regList[RegCount-1:0];

	// Whole list while idle, remainder once a transfer is under way
	assign curList = inReady ? fullList : remList;

	assign restList = curList & (curList - RegCount'(1)); // Lowest bit cleared

	assign lastXfer = (curList != '0) && (restList == '0);

	assign listCount = 12'($countones(fullList));
	assign stepBytes = 12'(WordBytes);

	// Lowest listed register goes first
	always_comb begin
		nextReg = 4'd0;
		for (int i = RegCount - 1; i >= 0; i--) begin
			if (curList[i]) begin
				nextReg = 4'(i);
			end
		end
	end

	// Start address relative to Rn, by P and U
	always_comb begin
		case ({instr.blk.p, instr.blk.u})
			2'b00: firstOffset = (listCount - 12'd1) * stepBytes; // DA, lowest at Rn-(n-1)*4
			2'b01: firstOffset = 12'd0;                          // IA
			2'b10: firstOffset = listCount * stepBytes;          // DB
			default: firstOffset = stepBytes;                    // IB
		endcase
	end

	assign addUp = instr.blk.u; // Subtract only for the decrement modes

	always_ff @(posedge clk) begin
		if (reset) begin
			remList <= '0;
		end else if (!stall) begin
			remList <= restList; // Drop the register just loaded
		end
	end

endmodule

// File: source/condCheck.sv
// Condition code check
`timescale 1ns/1ns
module condCheck (
	input logic [3:0] cond,
	input logic [3:0] flags, // NZCV
	output logic condPass
);
	logic n;
	logic z;
	logic c;
	logic v;

	assign n = flags[3];
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (cond)
			4'b0000: condPass = z;                // EQ
			4'b0001: condPass = ~z;               // NE
			4'b0010: condPass = c;                // CS
			4'b0011: condPass = ~c;               // CC
			4'b0100: condPass = n;                // MI
			4'b0101: condPass = ~n;               // PL
			4'b0110: condPass = v;                // VS
			4'b0111: condPass = ~v;               // VC
			4'b1000: condPass = c & ~z;           // HI
			4'b1001: condPass = ~c | z;           // LS
			4'b1010: condPass = (n == v);         // GE
			4'b1011: condPass = (n != v);         // LT
			4'b1100: condPass = ~z & (n == v);    // GT
			4'b1101: condPass = z | (n != v);     // LE
			4'b1110: condPass = 1'b1;             // AL
			default: condPass = 1'b0;             // NV
		endcase
	end

endmodule

// File: source/instrClassify.sv
// Instruction class decode
`timescale 1ns/1ns
module instrClassify (
	input uopPkg::instrWord_t instr,
	output uopPkg::instrClass_t instrClass
);
	import uopPkg::*;

	logic rsrShape;   // Operand shifted by a register
	logic mulShape;   // Multiply family signature
	logic linkBranch;
	logic blockLoad;

	// Bit 7 low and bit 4 high mark a register shift amount
	assign rsrShape = (instr.dp.opClass == ClassDpReg) &&
		!instr.dp.operand2[7] && instr.dp.operand2[4];

	// Bits 27:24 zero and 1001 in bits 7:4
	assign mulShape = (instr.dp.opClass == ClassDpReg) && !instr.dp.opcode[3] &&
		(instr.dp.operand2[7:4] == 4'b1001);

	assign linkBranch = ({instr.dp.opClass, instr.dp.opcode[3]} == 4'b1011);

	assign blockLoad = (instr.dp.opClass == ClassBlock) && instr.dp.s; // L bit

	always_comb begin
		if (rsrShape) begin
			instrClass = clRsr;
		end else if (mulShape && instr.dp.opcode[0] && !instr.dp.opcode[2]) begin
			instrClass = clMla; // Accumulate set, long clear
		end else if (linkBranch) begin
			instrClass = clBl;
		end else if (blockLoad) begin
			instrClass = clLdm;
		end else begin
			instrClass = clPass; // Includes long MLA
		end
	end

endmodule

// File: source/uopFsm.sv
// Micro-op sequencer FSM
`timescale 1ns/1ns
module uopFsm (
	input logic clk,
	input logic reset,
	input logic stall,
	input uopPkg::instrWord_t instr,
	input uopPkg::instrClass_t instrClass,
	input logic condPass,
	input logic [3:0] nextReg,
	input logic [11:0] firstOffset,
	input logic addUp,
	input logic lastXfer,
	output logic inReady,
	output uopPkg::instrWord_t uopInstr,
	output uopPkg::uopCtrl_t ctrl
);
	import uopPkg::*;

	uopState_t state;
	uopState_t nextState;

	// Single-word pre-indexed LDR with the base not written back
	function automatic instrWord_t buildLdr(
		input instrWord_t src,
		input logic [3:0] rd,
		input logic [11:0] offset,
		input logic up
	);
		instrWord_t word;
		word.blk.cond = src.blk.cond;
		word.blk.opClass = ClassSingle;
		word.blk.p = 1'b1;
		word.blk.u = up;
		word.blk.b = 1'b0; // Word access
		word.blk.w = 1'b0;
		word.blk.l = 1'b1;
		word.blk.rn = src.blk.rn;
		word.blk.low.single.rd = rd;
		word.blk.low.single.offset = offset;
		return word;
	endfunction

	assign inReady = (state == stReady); // Planner reloads the list

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stReady;
		end else if (!stall) begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stReady;
		uopInstr = instr; // Pass-through unless overridden
		ctrl = '0;
		case (state)
			stReady: begin
				case (instrClass)
					clRsr: begin
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = 1'b1;
						ctrl.regFileRz = RzWrite;
						uopInstr.dp.opcode = OpMov; // MOV Rz, Rm shift Rs
						uopInstr.dp.s = 1'b0;
						uopInstr.dp.rn = 4'd0;
						uopInstr.dp.rd = RegRz;
						nextState = stRsr;
					end
					clMla: begin
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = 1'b1;
						ctrl.regFileRz = RzWrite;
						uopInstr.dp.opcode = {2'b00, instr.dp.opcode[1], 1'b0}; // Keep sign bit
						uopInstr.dp.s = 1'b0;
						uopInstr.dp.rn = RegRz; // Multiply Rd field
						uopInstr.dp.rd = 4'd0;  // SBZ
						nextState = stMla;
					end
					clBl: begin
						ctrl.instrMux = 1'b1;
						ctrl.uopStall = 1'b1;
						uopInstr.dp.opClass = ClassDpReg;
						uopInstr.dp.opcode = OpMov; // MOV LR, PC
						uopInstr.dp.s = 1'b0;
						uopInstr.dp.rn = 4'd0;
						uopInstr.dp.rd = RegLr;
						uopInstr.dp.operand2 = {8'd0, RegPc};
						nextState = stBl;
					end
					clLdm: begin
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = !lastXfer;
						uopInstr = buildLdr(instr, nextReg, firstOffset, addUp);
						nextState = lastXfer ? stReady : stLdm;
					end
					default: nextState = stReady;
				endcase
			end
			stRsr: begin
				ctrl.instrMux = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.regFileRz = RzReadRa2;
				uopInstr.dp.operand2 = {8'd0, RegRz}; // Rz unshifted
			end
			stMla: begin
				ctrl.instrMux = 1'b1;
				ctrl.keepV = 1'b1;
				ctrl.prevRsr = 1'b1;
				ctrl.regFileRz = RzReadRa1;
				uopInstr.dp.opClass = ClassDpReg;
				uopInstr.dp.opcode = OpAdd; // ADD Rd, Rz, Ra
				uopInstr.dp.rn = RegRz;
				uopInstr.dp.rd = instr.dp.rn;
				uopInstr.dp.operand2 = {8'd0, instr.dp.rd};
			end
			stBl: begin
				ctrl.instrMux = 1'b1;
				uopInstr.dp.opcode[3] = 1'b0; // Plain branch
			end
			stLdm: begin
				if (!condPass) begin
					ctrl.noFlagUpdate = 1'b1; // Flush with a dead ADD
					uopInstr.dp.cond = CondNever;
					uopInstr.dp.opClass = ClassDpImm;
					uopInstr.dp.opcode = OpAdd;
					uopInstr.dp.s = 1'b0;
					uopInstr.dp.rn = 4'd0;
					uopInstr.dp.rd = 4'd0;
					uopInstr.dp.operand2 = '0;
				end else begin
					ctrl.instrMux = 1'b1;
					ctrl.noFlagUpdate = 1'b1;
					ctrl.uopStall = !lastXfer;
					ctrl.ldmForward = 1'b1; // Step from previous address
					uopInstr = buildLdr(instr, nextReg, 12'(WordBytes), 1'b1);
					nextState = lastXfer ? stReady : stLdm;
				end
			end
			default: nextState = stReady;
		endcase
	end

endmodule

// File: source/uopSequencer.sv
// Micro-op sequencer top
`timescale 1ns/1ns
module uopSequencer #(
	parameter int RegCount = 16 // LDM register list width
) (
	input logic clk,
	input logic reset,
	input uopPkg::instrWord_t instr,
	input logic [3:0] flags, // NZCV
	input logic stall,       // Pipeline back-pressure
	output uopPkg::instrWord_t uopInstr,
	output uopPkg::uopCtrl_t ctrl
);
	import uopPkg::*;

	instrClass_t instrClass;
	logic condPass;
	logic inReady;
	logic [3:0] nextReg;
	logic [11:0] firstOffset;
	logic addUp;
	logic lastXfer;

	condCheck i_condCheck (
		.cond(instr.dp.cond),
		.flags(flags),
		.condPass(condPass)
	);

	instrClassify i_instrClassify (
		.instr(instr),
		.instrClass(instrClass)
	);

	ldmPlanner #(
		.RegCount(RegCount)
	) i_ldmPlanner (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.inReady(inReady),
		.instr(instr),
		.nextReg(nextReg),
		.firstOffset(firstOffset),
		.addUp(addUp),
		.lastXfer(lastXfer)
	);

	uopFsm i_uopFsm (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.instrClass(instrClass),
		.condPass(condPass),
		.nextReg(nextReg),
		.firstOffset(firstOffset),
		.addUp(addUp),
		.lastXfer(lastXfer),
		.inReady(inReady),
		.uopInstr(uopInstr),
		.ctrl(ctrl)
	);

endmodule

// File: src.f
+incdir+dv
common/uopPkg.sv
source/condCheck.sv
source/instrClassify.sv
ldm/ldmPlanner.sv
source/uopFsm.sv
source/uopSequencer.sv
dv/clockGen.sv
dv/uopSequencerTb.sv
